// File: audio_pkg.sv
/*
 Shared widths, register map, reset values and bus structs of the audio playback controller.
 Every design file refers to these by scoped name.
*/

package audio_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 32;
	localparam int REG_ADDR_WIDTH = 4;
	localparam int SAMPLE_WIDTH = 16;

	// Byte step between consecutive stereo frames in memory
	localparam int WORD_BYTES = 4;

	localparam int CLOCK_HZ = 100_000_000;
	localparam int DEFAULT_SAMPLE_RATE = CLOCK_HZ / (256 * 22050);

	// Register map
	localparam logic [REG_ADDR_WIDTH-1:0] REG_SAMPLE_RATE = 4'd0;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_BUSY = 4'd1;
	// Channel k address at base + 2k, count at base + 2k + 1
	localparam int REG_CHANNEL_BASE = 1;

	// Left sample sits in the upper half of a DMA word
	typedef struct packed {
		logic signed [SAMPLE_WIDTH-1:0] left;
		logic signed [SAMPLE_WIDTH-1:0] right;
	} stereo_frame_t;

	typedef struct packed {
		logic start;
		logic [ADDR_WIDTH-1:0] address;
		logic [DATA_WIDTH-1:0] count;
	} channel_setup_t;

	typedef struct packed {
		logic request;
		logic [ADDR_WIDTH-1:0] address;
	} dma_request_t;

endpackage

// File: audio_register_file.sv
/*
 CPU register bus of the audio controller. Holds the sample-rate divisor and the
 per-channel setup registers, pulses a channel's start on a count write, reads back busy bits.
*/

`timescale 1ns/1ps

module audio_register_file #(
	parameter int NUM_CHANNELS = 4
)(
	input logic i_clock,
	input logic i_reset,

	input logic i_request,
	input logic i_rw,
	input logic [audio_pkg::REG_ADDR_WIDTH-1:0] i_address,
	input logic [audio_pkg::DATA_WIDTH-1:0] i_wdata,
	input logic [NUM_CHANNELS-1:0] i_busy,
	output logic [audio_pkg::DATA_WIDTH-1:0] o_rdata,
	output logic o_ready,

	output logic [audio_pkg::DATA_WIDTH-1:0] o_sample_rate,
	output audio_pkg::channel_setup_t o_setup [NUM_CHANNELS]
);

	logic access;
	logic write;
	logic [NUM_CHANNELS-1:0] address_hit;
	logic [NUM_CHANNELS-1:0] count_hit;
	logic [NUM_CHANNELS-1:0] start;
	logic [audio_pkg::ADDR_WIDTH-1:0] setup_address [NUM_CHANNELS];
	logic [audio_pkg::DATA_WIDTH-1:0] setup_count [NUM_CHANNELS];

	// One access per request, until o_ready has risen
	assign access = i_request && !o_ready;
	assign write = access && i_rw;

	always_comb begin
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			address_hit[k] = write && (i_address ==
				audio_pkg::REG_ADDR_WIDTH'(audio_pkg::REG_CHANNEL_BASE + 2 * k));
			count_hit[k] = write && (i_address ==
				audio_pkg::REG_ADDR_WIDTH'(audio_pkg::REG_CHANNEL_BASE + 2 * k + 1));
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			o_sample_rate <= audio_pkg::DATA_WIDTH'(audio_pkg::DEFAULT_SAMPLE_RATE);
			start <= '0;
		end else begin
			start <= count_hit;
			if (access)
				o_ready <= 1'b1;
			else if (!i_request)
				o_ready <= 1'b0;
			if (write && i_address == audio_pkg::REG_SAMPLE_RATE)
				o_sample_rate <= i_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (access && !i_rw) begin
			case (i_address)
				audio_pkg::REG_SAMPLE_RATE: o_rdata <= o_sample_rate;
				audio_pkg::REG_BUSY: o_rdata <= audio_pkg::DATA_WIDTH'(i_busy);
				default: o_rdata <= '0;
			endcase
		end
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			if (address_hit[k])
				setup_address[k] <= audio_pkg::ADDR_WIDTH'(i_wdata);
			if (count_hit[k])
				setup_count[k] <= i_wdata;
		end
	end

	for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_setup
		assign o_setup[k] = '{start: start[k], address: setup_address[k], count: setup_count[k]};
	end

	// A channel never sees its start together with another's
	start_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0(start));

endmodule

// File: audio_dma_scheduler.sv
/*
 Round-robin owner of the shared DMA master port. Serves one word at a time and
 routes the ready strobe back only to the channel under the pointer.
*/

`timescale 1ns/1ps

module audio_dma_scheduler #(
	parameter int NUM_CHANNELS = 4
)(
	input logic i_clock,
	input logic i_reset,

	input audio_pkg::dma_request_t i_channel_dma [NUM_CHANNELS],
	output logic [NUM_CHANNELS-1:0] o_grant,

	output logic o_dma_request,
	output logic [audio_pkg::ADDR_WIDTH-1:0] o_dma_address,
	input logic i_dma_ready
);

	localparam int INDEX_WIDTH = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

	logic [INDEX_WIDTH-1:0] pointer;
	logic [INDEX_WIDTH-1:0] pointer_next;
	logic served;

	// o_dma_request doubles as the waiting state
	assign served = o_dma_request && i_dma_ready;
	assign pointer_next = (pointer == INDEX_WIDTH'(NUM_CHANNELS - 1)) ? '0 : pointer + 1'b1;

	// The pointer rests on the granted channel until its word is served
	always_comb begin
		o_grant = '0;
		if (served)
			o_grant[pointer] = 1'b1;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_dma_request <= 1'b0;
			pointer <= '0;
		end else if (o_dma_request) begin
			if (i_dma_ready) begin
				o_dma_request <= 1'b0;
				pointer <= pointer_next;
			end
		end else if (i_channel_dma[pointer].request) begin
			o_dma_request <= 1'b1;
		end else begin
			pointer <= pointer_next;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!o_dma_request && i_channel_dma[pointer].request)
			o_dma_address <= i_channel_dma[pointer].address;
	end

	grant_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0(o_grant));

	// Request and address hold until the memory answers
	address_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_dma_request && !i_dma_ready |=> o_dma_request && $stable(o_dma_address));

endmodule

// File: audio_channel.sv
/*
 One playback channel. Fetches its frames through the DMA scheduler into a small FIFO
 and presents the oldest frame on each sample strobe.
*/

`timescale 1ns/1ps

module audio_channel #(
	parameter int BUFFER_SIZE = 4
)(
	input logic i_clock,
	input logic i_reset,

	input audio_pkg::channel_setup_t i_setup,

	output audio_pkg::dma_request_t o_dma,
	input logic i_grant,
	input logic [audio_pkg::DATA_WIDTH-1:0] i_dma_rdata,

	input logic i_sample_strobe,
	output logic o_busy,
	output audio_pkg::stereo_frame_t o_frame
);

	localparam int PTR_WIDTH = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
	localparam int LEVEL_WIDTH = $clog2(BUFFER_SIZE + 1);

	logic [audio_pkg::ADDR_WIDTH-1:0] address;
	logic [audio_pkg::DATA_WIDTH-1:0] count;
	audio_pkg::stereo_frame_t buffer [BUFFER_SIZE];
	logic [PTR_WIDTH-1:0] write_ptr;
	logic [PTR_WIDTH-1:0] read_ptr;
	logic [LEVEL_WIDTH-1:0] level;
	logic has_space;
	logic push;
	logic pop;

	function automatic logic [PTR_WIDTH-1:0] advance(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(BUFFER_SIZE - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign has_space = level < LEVEL_WIDTH'(BUFFER_SIZE);
	assign push = i_grant;
	assign pop = i_sample_strobe && (level != '0);

	assign o_busy = (count != '0);
	assign o_dma = '{request: o_busy && has_space, address: address};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
			write_ptr <= '0;
			read_ptr <= '0;
			level <= '0;
			o_frame <= '0;
		end else begin
			// A new setup replaces the count but keeps buffered frames
			if (i_setup.start)
				count <= i_setup.count;
			else if (push && o_busy)
				count <= count - 1'b1;
			if (push)
				write_ptr <= advance(write_ptr);
			if (pop)
				read_ptr <= advance(read_ptr);
			if (push && !pop)
				level <= level + 1'b1;
			else if (pop && !push)
				level <= level - 1'b1;
			// Silence when the FIFO has run dry
			if (i_sample_strobe)
				o_frame <= pop ? buffer[read_ptr] : '0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_setup.start)
			address <= i_setup.address;
		else if (push)
			address <= address + audio_pkg::ADDR_WIDTH'(audio_pkg::WORD_BYTES);
		if (push)
			buffer[write_ptr] <= audio_pkg::stereo_frame_t'(i_dma_rdata);
	end

	// The scheduler only serves a channel that still wants a word and has room
	grant_wanted: assert property (@(posedge i_clock) disable iff (i_reset)
		i_grant |-> o_busy && has_space);

endmodule

// File: audio_mixer.sv
/*
 Sums the current frames of all channels into one registered stereo sample.
 Sums wrap at the sample width.
*/

`timescale 1ns/1ps

module audio_mixer #(
	parameter int NUM_CHANNELS = 4
)(
	input logic i_clock,
	input logic i_reset,

	input audio_pkg::stereo_frame_t i_frames [NUM_CHANNELS],
	output logic signed [audio_pkg::SAMPLE_WIDTH-1:0] o_sample_left,
	output logic signed [audio_pkg::SAMPLE_WIDTH-1:0] o_sample_right
);

	logic signed [audio_pkg::SAMPLE_WIDTH-1:0] sum_left;
	logic signed [audio_pkg::SAMPLE_WIDTH-1:0] sum_right;

	always_comb begin
		sum_left = '0;
		sum_right = '0;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			sum_left = sum_left + i_frames[k].left;
			sum_right = sum_right + i_frames[k].right;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_sample_left <= '0;
			o_sample_right <= '0;
		end else begin
			o_sample_left <= sum_left;
			o_sample_right <= sum_right;
		end
	end

endmodule

// File: audio_controller.sv
/*
 Top level of the multi-channel audio playback controller.
 Connects the register file, DMA scheduler, channels and mixer.
*/

`timescale 1ns/1ps

module audio_controller #(
	parameter int NUM_CHANNELS = 4,
	parameter int BUFFER_SIZE = 4
)(
	input logic i_clock,
	input logic i_reset,

	input logic i_request,
	input logic i_rw,
	input logic [audio_pkg::REG_ADDR_WIDTH-1:0] i_address,
	input logic [audio_pkg::DATA_WIDTH-1:0] i_wdata,
	output logic [audio_pkg::DATA_WIDTH-1:0] o_rdata,
	output logic o_ready,

	output logic o_dma_request,
	output logic [audio_pkg::ADDR_WIDTH-1:0] o_dma_address,
	input logic i_dma_ready,
	input logic [audio_pkg::DATA_WIDTH-1:0] i_dma_rdata,

	input logic i_output_sample_clock,
	output logic [audio_pkg::DATA_WIDTH-1:0] o_output_sample_rate,
	output logic [audio_pkg::SAMPLE_WIDTH-1:0] o_output_sample_left,
	output logic [audio_pkg::SAMPLE_WIDTH-1:0] o_output_sample_right
);

	audio_pkg::channel_setup_t setup [NUM_CHANNELS];
	audio_pkg::dma_request_t channel_dma [NUM_CHANNELS];
	audio_pkg::stereo_frame_t frames [NUM_CHANNELS];
	logic [NUM_CHANNELS-1:0] grant;
	logic [NUM_CHANNELS-1:0] busy;

	audio_register_file #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_register_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_busy(busy),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_sample_rate(o_output_sample_rate),
		.o_setup(setup)
	);

	audio_dma_scheduler #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_dma_scheduler (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_channel_dma(channel_dma),
		.o_grant(grant),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address),
		.i_dma_ready(i_dma_ready)
	);

	for (genvar k = 0; k < NUM_CHANNELS; k++) begin : g_channel
		audio_channel #(
			.BUFFER_SIZE(BUFFER_SIZE)
		) u_channel (
			.i_clock(i_clock),
			.i_reset(i_reset),
			.i_setup(setup[k]),
			.o_dma(channel_dma[k]),
			.i_grant(grant[k]),
			.i_dma_rdata(i_dma_rdata),
			.i_sample_strobe(i_output_sample_clock),
			.o_busy(busy[k]),
			.o_frame(frames[k])
		);
	end

	audio_mixer #(
		.NUM_CHANNELS(NUM_CHANNELS)
	) u_mixer (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_frames(frames),
		.o_sample_left(o_output_sample_left),
		.o_sample_right(o_output_sample_right)
	);

endmodule

// File: tb_audio_controller.sv
/*
 Self-checking testbench for the audio controller. Programs channels over the CPU bus,
 answers DMA reads from a memory model and checks fetch order, busy bits and mixed output.
*/

`timescale 1ns/1ps

module tb_audio_controller;

	localparam int NUM_CHANNELS = 4;
	localparam int BUFFER_SIZE = 4;

	logic clock;
	logic reset;
	logic request;
	logic rw;
	logic [3:0] address;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic ready;
	logic dma_request;
	logic [31:0] dma_address;
	logic dma_ready;
	logic [31:0] dma_rdata;
	logic sample_clock;
	logic [31:0] sample_rate;
	logic [15:0] sample_left;
	logic [15:0] sample_right;

	// Expected state of each channel
	logic [31:0] next_address [NUM_CHANNELS];
	int remaining [NUM_CHANNELS];
	logic [31:0] model_fifo [NUM_CHANNELS][64];
	int head [NUM_CHANNELS];
	int tail [NUM_CHANNELS];
	int last_served;
	bit have_last;
	bit memory_enable;
	int max_delay;
	int loaded_words;
	int cycle_count;

	audio_controller #(
		.NUM_CHANNELS(NUM_CHANNELS),
		.BUFFER_SIZE(BUFFER_SIZE)
	) UUT (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_dma_request(dma_request),
		.o_dma_address(dma_address),
		.i_dma_ready(dma_ready),
		.i_dma_rdata(dma_rdata),
		.i_output_sample_clock(sample_clock),
		.o_output_sample_rate(sample_rate),
		.o_output_sample_left(sample_left),
		.o_output_sample_right(sample_right)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic require_true(input bit condition, input string what);
		assert (condition) else begin
			$display("ERROR at %0t ns: %s", $time, what);
			abort_run();
		end
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	// Memory contents as a fixed function of the byte address
	function automatic logic [31:0] memory_word(input logic [31:0] byte_address);
		return byte_address * 32'h9E37_79B1 + (byte_address >> 5);
	endfunction

	// Round-robin pick after the last served channel
	function automatic int next_in_order(input int last);
		for (int step = 1; step <= NUM_CHANNELS; step++) begin
			if (remaining[(last + step) % NUM_CHANNELS] != 0)
				return (last + step) % NUM_CHANNELS;
		end
		return -1;
	endfunction

	task automatic serve_word(input logic [31:0] served_address);
		int channel;
		channel = -1;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			if (remaining[k] != 0 && next_address[k] == served_address)
				channel = k;
		end
		require_true(channel >= 0, "DMA address does not match any channel's next frame");
		if (have_last)
			compare_value("served channel", next_in_order(last_served), channel);
		model_fifo[channel][tail[channel]] = memory_word(served_address);
		tail[channel]++;
		next_address[channel] += audio_pkg::WORD_BYTES;
		remaining[channel]--;
		last_served = channel;
		have_last = 1'b1;
	endtask

	// Memory side of the DMA port with a random wait before each answer
	always begin
		logic [31:0] held_address;
		int hold;
		@(negedge clock);
		if (memory_enable && dma_request) begin
			held_address = dma_address;
			hold = $urandom_range(max_delay, 0);
			repeat (hold) begin
				@(negedge clock);
				require_true(dma_request, "o_dma_request dropped before ready");
				compare_value("o_dma_address", held_address, dma_address);
			end
			serve_word(held_address);
			dma_ready = 1'b1;
			dma_rdata = memory_word(held_address);
			@(negedge clock);
			dma_ready = 1'b0;
			require_true(!dma_request, "o_dma_request did not fall after ready");
		end
	end

	task automatic cpu_access(input logic write, input logic [3:0] index,
		input logic [31:0] data, output logic [31:0] result);
		int hold;
		hold = $urandom_range(2, 0);
		require_true(!ready, "o_ready high before a new request");
		request = 1'b1;
		rw = write;
		address = index;
		wdata = data;
		@(negedge clock);
		require_true(ready, "o_ready did not rise one edge after the request");
		result = rdata;
		repeat (hold) begin
			@(negedge clock);
			require_true(ready, "o_ready fell while the request was held");
		end
		request = 1'b0;
		@(negedge clock);
		require_true(!ready, "o_ready did not fall one edge after the request dropped");
	endtask

	task automatic play_phase(input int hold_limit);
		logic [31:0] value;
		logic [31:0] frame;
		logic [15:0] sum_left;
		logic [15:0] sum_right;
		int count;
		memory_enable = 1'b0;
		max_delay = hold_limit;
		have_last = 1'b0;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			count = $urandom_range(BUFFER_SIZE, 1);
			next_address[k] = (k << 24) | ($urandom & 32'h00FF_FFFC);
			remaining[k] = count;
			loaded_words += count;
			cpu_access(1'b1, 4'(1 + 2 * k), next_address[k], value);
			cpu_access(1'b1, 4'(2 + 2 * k), count, value);
		end
		cpu_access(1'b0, audio_pkg::REG_BUSY, '0, value);
		compare_value("REG_BUSY", (1 << NUM_CHANNELS) - 1, value);
		memory_enable = 1'b1;
		do
			cpu_access(1'b0, audio_pkg::REG_BUSY, '0, value);
		while (value != 0);
		for (int k = 0; k < NUM_CHANNELS; k++)
			compare_value("words left to fetch", 0, remaining[k]);
		// One extra strobe shows the silence of empty FIFOs
		for (int s = 0; s <= BUFFER_SIZE; s++) begin
			sum_left = '0;
			sum_right = '0;
			for (int k = 0; k < NUM_CHANNELS; k++) begin
				if (head[k] != tail[k]) begin
					frame = model_fifo[k][head[k]];
					head[k]++;
					sum_left += frame[31:16];
					sum_right += frame[15:0];
				end
			end
			sample_clock = 1'b1;
			@(negedge clock);
			sample_clock = 1'b0;
			@(negedge clock);
			compare_value("o_output_sample_left", sum_left, sample_left);
			compare_value("o_output_sample_right", sum_right, sample_right);
		end
	endtask

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count > 2000 + 200 * loaded_words) begin
				$display("ERROR: watchdog timeout after %0d cycles", cycle_count);
				abort_run();
			end
		end
	end

	initial begin
		logic [31:0] value;
		logic [31:0] rate;
		void'($urandom(73188));
		reset = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		dma_ready = 1'b0;
		dma_rdata = '0;
		sample_clock = 1'b0;
		memory_enable = 1'b0;
		max_delay = 0;
		loaded_words = 0;
		have_last = 1'b0;
		last_served = 0;
		for (int k = 0; k < NUM_CHANNELS; k++) begin
			head[k] = 0;
			tail[k] = 0;
			remaining[k] = 0;
		end
		repeat (2) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		cpu_access(1'b0, audio_pkg::REG_SAMPLE_RATE, '0, value);
		compare_value("REG_SAMPLE_RATE", 17, value);
		rate = $urandom;
		cpu_access(1'b1, audio_pkg::REG_SAMPLE_RATE, rate, value);
		cpu_access(1'b0, audio_pkg::REG_SAMPLE_RATE, '0, value);
		compare_value("REG_SAMPLE_RATE", rate, value);
		compare_value("o_output_sample_rate", rate, sample_rate);
		cpu_access(1'b0, 4'd15, '0, value);
		compare_value("unmapped read", 0, value);
		cpu_access(1'b0, 4'($urandom_range(15, 2)), '0, value);
		compare_value("write-only read", 0, value);

		// Short memory waits, then long ones as back-pressure
		play_phase(5);
		play_phase(30);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: filelist.f
audio_pkg.sv
audio_register_file.sv
audio_dma_scheduler.sv
audio_channel.sv
audio_mixer.sv
audio_controller.sv
tb_audio_controller.sv
